// ==== taConfigVectors.txt ====
# Columns: mode (hex, ssp ged gainMsb gainLsb testMode) and disable mask (hex)
# followed by the expected status mode and mask
15 DEADBEEF 15 DEADBEEF
00 00000000 00 00000000
1F FFFFFFFF 1F FFFFFFFF
01 00000001 01 00000001
10 80000000 10 80000000
0A 55555555 0A 55555555
15 AAAAAAAA 15 AAAAAAAA
02 0000FFFF 02 0000FFFF
04 FFFF0000 04 FFFF0000
08 12345678 08 12345678
1C 87654321 1C 87654321
03 0F0F0F0F 03 0F0F0F0F
11 F0F0F0F0 11 F0F0F0F0
1E 00C0FFEE 1E 00C0FFEE

// ==== vlog.f ====
taCfgPkg.sv
configSerializer.sv
readbackSampler.sv
taConfigSequencer.sv
taConfig.sv
taChipModel.sv
taConfigTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the TA configuration testbench with Verilator and runs it

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module taConfigTb -f vlog.f -o taConfigSim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/taConfigSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== taConfigTb.sv ====
/*
 * TA configuration testbench
 * Reads request vectors, drives the handshake and checks status,
 * chip pin timing and the words latched in the chip model.
 */
`timescale 1ns/10ps
`default_nettype none

module taConfigTb;

  logic                                        Clk;
  logic                                        Rst_n;
  logic                                        CfgValid;
  taCfgPkg::taRequest                          CfgReq;
  logic                                        CfgReady;
  taCfgPkg::taRequest                          Status;
  logic                                        StatusValid;
  logic [taCfgPkg::NumChips-1:0]               RegIn;
  logic [taCfgPkg::NumChips-1:0]               chipRegOut;
  logic                                        ClkTa;
  logic                                        Load;
  logic                                        ReadBack;
  taCfgPkg::taCmdWord [taCfgPkg::NumChips-1:0] latched;

  taCfgPkg::taRequest reqQ[$];
  taCfgPkg::taRequest expQ[$];
  int                 errorCount;
  int                 checkCount;
  int                 cycleCount;
  int                 cycleLimit;
  logic               limitReady;
  logic               earlyReady;
  logic               prevClkTa;
  logic               prevLoad;
  logic               prevReadBack;
  logic [15:0]        clkHighLen;
  logic [15:0]        loadLen;
  logic [15:0]        readLen;

  taConfig taConfig_inst (
    .Clk(Clk), .Rst_n(Rst_n),
    .CfgValid(CfgValid), .CfgReq(CfgReq), .CfgReady(CfgReady),
    .Status(Status), .StatusValid(StatusValid),
    .RegIn(RegIn), .RegOut(chipRegOut[0]),
    .ClkTa(ClkTa), .Load(Load), .ReadBack(ReadBack)
  );

  taChipModel taChipModel_inst (
    .ClkTa(ClkTa), .Load(Load), .ReadBack(ReadBack),
    .RegIn(RegIn), .RegOut(chipRegOut), .Latched(latched)
  );

  task automatic checkRequest(input string name, input taCfgPkg::taRequest got,
                              input taCfgPkg::taRequest exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic checkWord(input string name, input taCfgPkg::taCmdWord got,
                           input taCfgPkg::taCmdWord exp);
    checkCount++;
    if (got.flat !== exp.flat)
    begin
      errorCount++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got.flat, exp.flat);
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkWidth(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic readVectors();
    int                 fd;
    int                 fields;
    string              line;
    logic [4:0]         mode;
    logic [4:0]         expMode;
    logic [31:0]        mask;
    logic [31:0]        expMask;
    taCfgPkg::taRequest req;
    taCfgPkg::taRequest exp;
    fd = $fopen("taConfigVectors.txt", "r");
    if (fd == 0)
    begin
      errorCount++;
      $display("Could not open the vector file taConfigVectors.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        fields = $sscanf(line, "%h %h %h %h", mode, mask, expMode, expMask);
        if (fields == 4)                                  // Skips comment lines
        begin
          req.disableMask = mask;
          req.mode        = mode;
          exp.disableMask = expMask;
          exp.mode        = expMode;
          reqQ.push_back(req);
          expQ.push_back(exp);
        end
      end
      $fclose(fd);
    end
    if (reqQ.size() == 0)
    begin
      errorCount++;
      $display("No request vectors were read");
    end
  endtask

  // Latched word is test mask, trims, disable mask, mode from the top down
  task automatic checkLatched(input taCfgPkg::taRequest req);
    taCfgPkg::taCmdWord exp;
    exp.flat = {32'h0, 96'h0, req.disableMask, req.mode};
    for (int k = 0; k < taCfgPkg::NumChips; k++)
      checkWord($sformatf("Latched[%0d]", k), latched[k], exp);
  endtask

  task automatic checkResetLevels();
    checkLevel("CfgReady", CfgReady, 1'b1);
    checkLevel("ClkTa", ClkTa, 1'b0);
    checkLevel("Load", Load, 1'b0);
    checkLevel("ReadBack", ReadBack, 1'b0);
    checkLevel("StatusValid", StatusValid, 1'b0);
    for (int k = 0; k < taCfgPkg::NumChips; k++)
      checkLevel($sformatf("RegIn[%0d]", k), RegIn[k], 1'b0);
  endtask

  initial
  begin
    Clk = 1'b0;
    forever #4 Clk = ~Clk;
  end

  // Pin timing is checked on falling edges where the pins are settled
  always @(negedge Clk)
  begin
    if (Rst_n)
    begin
      if (ClkTa && !prevClkTa)
        for (int k = 1; k < taCfgPkg::NumChips; k++)
          checkLevel($sformatf("RegIn[%0d]", k), RegIn[k], RegIn[0]);
      if (Load && ClkTa !== prevClkTa)
      begin
        errorCount++;
        $display("ClkTa changed while Load was high at %0t", $time);
      end
      if (!ClkTa && prevClkTa)
        checkWidth("ClkTa high cycles", clkHighLen, 16'(taCfgPkg::ClkHighCycles));
      if (!Load && prevLoad)
        checkWidth("Load cycles", loadLen, 16'(taCfgPkg::LoadCycles));
      if (!ReadBack && prevReadBack)
        checkWidth("ReadBack cycles", readLen, 16'(taCfgPkg::ReadPulseCycles));
      clkHighLen   = ClkTa ? clkHighLen + 1'b1 : '0;
      loadLen      = Load ? loadLen + 1'b1 : '0;
      readLen      = ReadBack ? readLen + 1'b1 : '0;
      prevClkTa    = ClkTa;
      prevLoad     = Load;
      prevReadBack = ReadBack;
    end
  end

  initial
  begin
    wait (limitReady);
    while (cycleCount < cycleLimit)
    begin
      @(posedge Clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles without finishing the vectors", cycleCount);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount + 1);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    Rst_n        = 1'b0;
    CfgValid     = 1'b0;
    CfgReq       = '0;
    errorCount   = 0;
    checkCount   = 0;
    cycleCount   = 0;
    limitReady   = 1'b0;
    prevClkTa    = 1'b0;
    prevLoad     = 1'b0;
    prevReadBack = 1'b0;
    clkHighLen   = '0;
    loadLen      = '0;
    readLen      = '0;
    readVectors();
    cycleLimit = 2 * reqQ.size() * (int'(taCfgPkg::CmdLength) * 41 + 200) + 20;
    limitReady = 1'b1;
    repeat (2) @(posedge Clk);
    @(negedge Clk);
    Rst_n = 1'b1;
    @(negedge Clk);
    checkResetLevels();
    if (reqQ.size() > 0)
    begin
      CfgReq   = reqQ[0];
      CfgValid = 1'b1;
    end
    for (int i = 0; i < reqQ.size(); i++)
    begin
      checkLevel("CfgReady", CfgReady, 1'b1);   // Taken on the next rising edge
      @(negedge Clk);
      if (i + 1 < reqQ.size())
        CfgReq = reqQ[i + 1];                   // Next request stays valid while busy
      else
      begin
        CfgValid = 1'b0;
        CfgReq   = '0;
      end
      earlyReady = 1'b0;
      while (!StatusValid)
      begin
        if (!earlyReady)
        begin
          checkLevel("CfgReady while busy", CfgReady, 1'b0);
          earlyReady = CfgReady;
        end
        @(negedge Clk);
      end
      checkRequest("Status", Status, expQ[i]);
      checkLatched(reqQ[i]);
    end
    repeat (4) @(negedge Clk);
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== taChipModel.sv ====
/*
 * TA chip bank model
 * Four chips, each with a 165-bit input shift register, a load latch
 * and a readback shifter clocked out on RegOut.
 */
`timescale 1ns/10ps
`default_nettype none

module taChipModel (
  input  logic                                              ClkTa,
  input  logic                                              Load,
  input  logic                                              ReadBack,
  input  logic [taCfgPkg::NumChips-1:0]                     RegIn,
  output logic [taCfgPkg::NumChips-1:0]                     RegOut,
  output taCfgPkg::taCmdWord [taCfgPkg::NumChips-1:0]       Latched
);

  logic [taCfgPkg::CmdLength-1:0] shiftReg [taCfgPkg::NumChips];
  logic [taCfgPkg::CmdLength-1:0] rbShift  [taCfgPkg::NumChips];

  // First bit sent ends up at the top position
  always @(posedge ClkTa)
  begin
    for (int i = 0; i < taCfgPkg::NumChips; i++)
      shiftReg[i] <= {shiftReg[i][taCfgPkg::CmdLength-2:0], RegIn[i]};
  end

  always @(negedge Load)
  begin
    for (int i = 0; i < taCfgPkg::NumChips; i++)
      Latched[i].flat <= shiftReg[i];
  end

  // ReadBack high loads, its fall and each ClkTa fall present the next bit
  always @(posedge ReadBack or negedge ReadBack or negedge ClkTa)
  begin
    for (int i = 0; i < taCfgPkg::NumChips; i++)
    begin
      if (ReadBack)
        rbShift[i] <= Latched[i].flat;
      else
      begin
        RegOut[i]  <= rbShift[i][taCfgPkg::CmdLength-1];
        rbShift[i] <= rbShift[i] << 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== taConfig.sv ====
/*
 * TA configuration top
 * Connects sequencer, serializer and readback sampler to the TA chip pins.
 */
`timescale 1ns/10ps
`default_nettype none

module taConfig (
  input  logic                          Clk,
  input  logic                          Rst_n,
  input  logic                          CfgValid,
  input  taCfgPkg::taRequest            CfgReq,
  output logic                          CfgReady,
  output taCfgPkg::taRequest            Status,
  output logic                          StatusValid,
  output logic [taCfgPkg::NumChips-1:0] RegIn,
  input  logic                          RegOut,
  output logic                          ClkTa,
  output logic                          Load,
  output logic                          ReadBack
);

  taCfgPkg::taCfgPins  cfgPins;
  taCfgPkg::taReadPins readPins;
  taCfgPkg::taCmdWord  serWord;
  taCfgPkg::taCmdWord  rbWord;
  logic                serStart;
  logic                serDone;
  logic                rbStart;
  logic                rbDone;

  assign RegIn    = {taCfgPkg::NumChips{cfgPins.regIn}};   // Same word to every chip
  assign Load     = cfgPins.load;
  assign ReadBack = readPins.readBack;

  taConfigSequencer taConfigSequencer_inst (
    .Clk(Clk), .Rst_n(Rst_n),
    .CfgValid(CfgValid), .CfgReq(CfgReq), .CfgReady(CfgReady),
    .CfgPins(cfgPins), .ReadPins(readPins),
    .SerDone(serDone), .RbDone(rbDone), .RbWord(rbWord),
    .SerStart(serStart), .SerWord(serWord), .RbStart(rbStart),
    .ClkTa(ClkTa), .Status(Status), .StatusValid(StatusValid)
  );

  configSerializer configSerializer_inst (
    .Clk(Clk), .Rst_n(Rst_n),
    .Start(serStart), .Word(serWord),
    .Pins(cfgPins), .Done(serDone)
  );

  readbackSampler readbackSampler_inst (
    .Clk(Clk), .Rst_n(Rst_n),
    .Start(rbStart), .RegOut(RegOut),
    .Pins(readPins), .Word(rbWord), .Done(rbDone)
  );

endmodule

`default_nettype wire

// ==== taConfigSequencer.sv ====
/*
 * TA config sequencer
 * Accepts a request, runs the serializer and then the sampler, steers
 * the chip clock and publishes the read-back mode and mask as status.
 */
`timescale 1ns/10ps
`default_nettype none

module taConfigSequencer (
  input  logic                Clk,
  input  logic                Rst_n,
  input  logic                CfgValid,
  input  taCfgPkg::taRequest  CfgReq,
  output logic                CfgReady,
  input  taCfgPkg::taCfgPins  CfgPins,
  input  taCfgPkg::taReadPins ReadPins,
  input  logic                SerDone,
  input  logic                RbDone,
  input  taCfgPkg::taCmdWord  RbWord,
  output logic                SerStart,
  output taCfgPkg::taCmdWord  SerWord,
  output logic                RbStart,
  output logic                ClkTa,
  output taCfgPkg::taRequest  Status,
  output logic                StatusValid
);

  enum logic [1:0] {idle, configuring, reading} state;

  logic clkSel;   // 1 while the sampler owns ClkTa

  assign CfgReady = (state == idle);
  // Both sources are low at every switch point
  assign ClkTa    = clkSel ? ReadPins.clkTa : CfgPins.clkTa;

  always_ff @(posedge Clk or negedge Rst_n)
  begin
    if (!Rst_n)
    begin
      state       <= idle;
      clkSel      <= 1'b0;
      SerStart    <= 1'b0;
      RbStart     <= 1'b0;
      StatusValid <= 1'b0;
    end
    else
    begin
      SerStart    <= 1'b0;
      RbStart     <= 1'b0;
      StatusValid <= 1'b0;
      case (state)
        idle:
        begin
          if (CfgValid)
          begin
            state    <= configuring;
            SerStart <= 1'b1;
          end
        end
        configuring:
        begin
          if (SerDone)
          begin
            state   <= reading;
            RbStart <= 1'b1;
            clkSel  <= 1'b1;                    // Hand ClkTa to the sampler
          end
        end
        reading:
        begin
          if (RbDone)
          begin
            state       <= idle;
            clkSel      <= 1'b0;
            StatusValid <= 1'b1;
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

  always_ff @(posedge Clk)
  begin
    if (CfgValid && CfgReady)
      SerWord.fields <= '{testMask: '0, trimDacs: '0,
                          disableMask: CfgReq.disableMask, mode: CfgReq.mode};
    if (RbDone)
      Status <= '{disableMask: RbWord.fields.disableMask, mode: RbWord.fields.mode};
  end

endmodule

`default_nettype wire

// ==== readbackSampler.sv ====
/*
 * Readback sampler
 * Pulses ReadBack, then clocks the command word back from chip 1 and
 * keeps the returned mask and mode bits.
 */
`timescale 1ns/10ps
`default_nettype none

module readbackSampler (
  input  logic                Clk,
  input  logic                Rst_n,
  input  logic                Start,
  input  logic                RegOut,
  output taCfgPkg::taReadPins Pins,
  output taCfgPkg::taCmdWord  Word,
  output logic                Done
);

  enum logic [2:0] {idle, readPulse, waitGap, clockHigh, recovery} state;

  logic [taCfgPkg::PhaseCntWidth-1:0] phaseCnt;
  logic [taCfgPkg::PhaseCntWidth-1:0] phaseLast;
  logic [taCfgPkg::BitCntWidth-1:0]   bitCnt;     // Position being read back
  logic                               phaseEnd;
  taCfgPkg::taRequest                 rbFields;   // Read-back mask and mode

  always_comb
  begin
    case (state)
      readPulse: phaseLast = taCfgPkg::ReadPulseCycles - 1'b1;
      waitGap:   phaseLast = taCfgPkg::ReadWaitCycles - 1'b1;
      clockHigh: phaseLast = taCfgPkg::ClkHighCycles - 1'b1;
      recovery:  phaseLast = taCfgPkg::RecoveryCycles - 1'b1;
      default:   phaseLast = '0;
    endcase
  end

  assign phaseEnd = (phaseCnt == phaseLast);

  always_ff @(posedge Clk or negedge Rst_n)
  begin
    if (!Rst_n)
    begin
      state    <= idle;
      phaseCnt <= '0;
      bitCnt   <= '0;
      Pins     <= '0;
      Done     <= 1'b0;
    end
    else
    begin
      Done <= 1'b0;
      if (state != idle)
        phaseCnt <= phaseEnd ? '0 : phaseCnt + 1'b1;
      case (state)
        idle:
        begin
          phaseCnt <= '0;
          if (Start)
          begin
            state         <= readPulse;
            bitCnt        <= taCfgPkg::CmdLength - 1'b1;
            Pins.readBack <= 1'b1;                      // Chips load their shifters
          end
        end
        readPulse:
        begin
          if (phaseEnd)
          begin
            state         <= waitGap;
            Pins.readBack <= 1'b0;                      // First bit appears on RegOut
          end
        end
        waitGap:
        begin
          if (phaseEnd)
          begin
            state      <= clockHigh;
            Pins.clkTa <= 1'b1;
          end
        end
        clockHigh:
        begin
          if (phaseEnd)
          begin
            state      <= recovery;
            Pins.clkTa <= 1'b0;                         // Fall moves chip to next bit
          end
        end
        recovery:
        begin
          if (phaseEnd && bitCnt == '0)
          begin
            state <= idle;
            Done  <= 1'b1;
          end
          else if (phaseEnd)
          begin
            state      <= clockHigh;
            bitCnt     <= bitCnt - 1'b1;
            Pins.clkTa <= 1'b1;
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

  // Sample on the last high cycle, well after RegOut settled
  always_ff @(posedge Clk)
  begin
    if (state == clockHigh && phaseEnd && bitCnt < $bits(taCfgPkg::taRequest))
      rbFields[bitCnt[5:0]] <= RegOut;
  end

  // Test mask and trims are not kept and read as zero
  always_comb
  begin
    Word                    = '0;
    Word.fields.disableMask = rbFields.disableMask;
    Word.fields.mode        = rbFields.mode;
  end

endmodule

`default_nettype wire

// ==== configSerializer.sv ====
/*
 * Config serializer
 * Shifts the command word out MSB first with set-up, clock-high and
 * recovery phases per bit, then issues the load pulse.
 */
`timescale 1ns/10ps
`default_nettype none

module configSerializer (
  input  logic               Clk,
  input  logic               Rst_n,
  input  logic               Start,
  input  taCfgPkg::taCmdWord Word,
  output taCfgPkg::taCfgPins Pins,
  output logic               Done
);

  enum logic [2:0] {idle, setup, clockHigh, recovery, load} state;

  logic [taCfgPkg::PhaseCntWidth-1:0] phaseCnt;
  logic [taCfgPkg::PhaseCntWidth-1:0] phaseLast;
  logic [taCfgPkg::BitCntWidth-1:0]   bitCnt;     // Position of the bit on RegIn
  logic                               phaseEnd;

  always_comb
  begin
    case (state)
      setup:     phaseLast = taCfgPkg::SetupCycles - 1'b1;
      clockHigh: phaseLast = taCfgPkg::ClkHighCycles - 1'b1;
      recovery:  phaseLast = taCfgPkg::RecoveryCycles - 1'b1;
      load:      phaseLast = taCfgPkg::LoadCycles - 1'b1;
      default:   phaseLast = '0;
    endcase
  end

  assign phaseEnd = (phaseCnt == phaseLast);

  always_ff @(posedge Clk or negedge Rst_n)
  begin
    if (!Rst_n)
    begin
      state    <= idle;
      phaseCnt <= '0;
      bitCnt   <= '0;
      Pins     <= '0;
      Done     <= 1'b0;
    end
    else
    begin
      Done <= 1'b0;
      if (state != idle)
        phaseCnt <= phaseEnd ? '0 : phaseCnt + 1'b1;
      case (state)
        idle:
        begin
          phaseCnt <= '0;
          if (Start)
          begin
            state      <= setup;
            bitCnt     <= taCfgPkg::CmdLength - 1'b1;               // Top position first
            Pins.regIn <= Word.flat[taCfgPkg::CmdLength - 1'b1];
          end
        end
        setup:
        begin
          if (phaseEnd)
          begin
            state      <= clockHigh;
            Pins.clkTa <= 1'b1;                                   // Chip samples on this rise
          end
        end
        clockHigh:
        begin
          if (phaseEnd)
          begin
            state      <= recovery;
            Pins.clkTa <= 1'b0;
          end
        end
        recovery:
        begin
          if (phaseEnd && bitCnt == '0)
          begin
            state      <= load;
            Pins.regIn <= 1'b0;
            Pins.load  <= 1'b1;
          end
          else if (phaseEnd)
          begin
            state      <= setup;
            bitCnt     <= bitCnt - 1'b1;
            Pins.regIn <= Word.flat[bitCnt - 1'b1];               // Next bit down
          end
        end
        load:
        begin
          if (phaseEnd)
          begin
            state     <= idle;
            Pins.load <= 1'b0;
            Done      <= 1'b1;                                    // Word latched in the chips
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== taCfgPkg.sv ====
/*
 * TA configuration package
 * Phase lengths, field widths and the shared types for the TA front-end
 * configuration link: command word, request/status and pin bundles.
 */
`default_nettype none

package taCfgPkg;

  localparam int unsigned PhaseCntWidth = 6;
  localparam int unsigned BitCntWidth   = 8;
  localparam int unsigned NumChips      = 4;    // RegIn lanes driven in parallel

  localparam logic [BitCntWidth-1:0] CmdLength = 8'd165;  // Bits per command word

  // Phase lengths in system clock cycles
  localparam logic [PhaseCntWidth-1:0] SetupCycles     = 6'd5;
  localparam logic [PhaseCntWidth-1:0] ClkHighCycles   = 6'd8;
  localparam logic [PhaseCntWidth-1:0] RecoveryCycles  = 6'd10;
  localparam logic [PhaseCntWidth-1:0] LoadCycles      = 6'd50;
  localparam logic [PhaseCntWidth-1:0] ReadPulseCycles = 6'd50;
  localparam logic [PhaseCntWidth-1:0] ReadWaitCycles  = 6'd10;

  typedef struct packed {
    logic ssp;        // Signal polarity select
    logic ged;        // Gain stage bypass
    logic gainMsb;
    logic gainLsb;
    logic testMode;
  } taMode;

  typedef struct packed {
    logic [31:0] disableMask;  // One bit per channel, 1 disables
    taMode       mode;
  } taRequest;

  typedef struct packed {
    logic [31:0] testMask;     // Sent as zero
    logic [95:0] trimDacs;     // 3-bit trims, sent as zero
    logic [31:0] disableMask;
    taMode       mode;
  } taCmdFields;

  // Serializer and sampler walk the flat view, the sequencer fills the fields
  typedef union packed {
    logic [CmdLength-1:0] flat;
    taCmdFields           fields;
  } taCmdWord;

  typedef struct packed {
    logic regIn;
    logic clkTa;
    logic load;
  } taCfgPins;

  typedef struct packed {
    logic readBack;
    logic clkTa;
  } taReadPins;

endpackage

`default_nettype wire
